//--- rtl/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// operand and result width
`define DATA_WIDTH 16

// general purpose registers
`define REG_COUNT 16

// immediate field width
`define IMM_WIDTH 8

`endif

//--- rtl/aluOpPkg.sv
package aluOpPkg;

	// ------------------------------
	// opcodes
	// ------------------------------

	// 5-bit field, codes 11..31 unused
	typedef enum logic [4:0] {
		ADD  = 5'd0,
		SUB  = 5'd1,
		CMP  = 5'd2,
		AND  = 5'd3,
		OR   = 5'd4,
		XOR  = 5'd5,
		NOT  = 5'd6,
		LSH  = 5'd7,
		RSH  = 5'd8,
		ARSH = 5'd9,
		MOV  = 5'd10
	} opCode;

	// ------------------------------
	// status flags
	// ------------------------------

	// one bit per flag, positions below
	typedef logic [4:0] flagVec;

	// carry out of the adder
	localparam int flagC = 0;
	// unsigned less than
	localparam int flagL = 1;
	// signed overflow
	localparam int flagF = 2;
	// zero sum
	localparam int flagZ = 3;
	// signed less than
	localparam int flagN = 4;

endpackage

//--- rtl/instrPkg.sv
`include "exec_params.svh"

package instrPkg;

	// ------------------------------
	// instruction format
	// ------------------------------

	// register number, 0..REG_COUNT-1
	typedef logic [$clog2(`REG_COUNT)-1:0] regIdx;

	// 23-bit word, msb first
	typedef struct packed {
		// operation
		aluOpPkg::opCode op;
		// second operand from imm instead of rSrc
		logic immSel;
		// sign extend imm, else zero fill
		logic signExt;
		// destination, also operand A
		regIdx rDest;
		// source register for operand B
		regIdx rSrc;
		// raw immediate
		logic [`IMM_WIDTH-1:0] imm;
	} instrWord;

endpackage

//--- rtl/alu.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module alu (
	input  logic [`DATA_WIDTH-1:0] a,
	input  logic [`DATA_WIDTH-1:0] b,
	input  aluOpPkg::opCode        op,
	output logic [`DATA_WIDTH-1:0] y,
	output aluOpPkg::flagVec       flagsOut
);

	// sign bit position
	localparam int msb = `DATA_WIDTH - 1;

	// subtract select, SUB and CMP
	logic isSub;
	// adder second input, b or ~b
	logic [`DATA_WIDTH-1:0] addB;
	// extra top bit holds carry out
	logic [`DATA_WIDTH:0] sum;
	// signed overflow of add or subtract
	logic overflow;

	// ------------------------------
	// shared adder
	// ------------------------------

	assign isSub = (op == aluOpPkg::SUB) || (op == aluOpPkg::CMP);

	// a - b as a + ~b + 1
	assign addB = isSub ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, addB} + {{`DATA_WIDTH{1'b0}}, isSub};

	// inputs to the adder agree in sign, result does not
	// for subtract this means a and b differ in sign
	assign overflow = (a[msb] == addB[msb]) && (sum[msb] != a[msb]);

	// ------------------------------
	// flags
	// ------------------------------

	// always computed, core decides when to latch
	always_comb begin
		flagsOut = '0;
		flagsOut[aluOpPkg::flagC] = sum[`DATA_WIDTH];
		// unsigned compare
		flagsOut[aluOpPkg::flagL] = a < b;
		flagsOut[aluOpPkg::flagF] = overflow;
		// zero on the truncated sum
		flagsOut[aluOpPkg::flagZ] = (sum[msb:0] == '0);
		// signed compare
		flagsOut[aluOpPkg::flagN] = $signed(a) < $signed(b);
	end

	// ------------------------------
	// result select
	// ------------------------------

	always_comb begin
		case (op)
			// CMP still shows the difference
			aluOpPkg::ADD,
			aluOpPkg::SUB,
			aluOpPkg::CMP:
				y = sum[msb:0];
			aluOpPkg::AND:
				y = a & b;
			aluOpPkg::OR:
				y = a | b;
			aluOpPkg::XOR:
				y = a ^ b;
			// bitwise, every bit of b flipped
			aluOpPkg::NOT:
				y = ~b;
			// single bit shifts of operand b
			aluOpPkg::LSH:
				y = {b[msb-1:0], 1'b0};
			aluOpPkg::RSH:
				y = {1'b0, b[msb:1]};
			// sign bit copied down
			aluOpPkg::ARSH:
				y = {b[msb], b[msb:1]};
			aluOpPkg::MOV:
				y = b;
			default:
				y = '0;
		endcase
	end

	// opcode from decode stays inside the defined set
	illegalOpCheck: assert property (@(op) $isunknown(op) || (op <= aluOpPkg::MOV))
		else $error("alu: illegal opcode %0d", op);

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module regFile (
	input  logic                   clk,
	input  logic                   rstN,
	input  instrPkg::regIdx        rdIdx,
	input  instrPkg::regIdx        rsIdx,
	input  instrPkg::regIdx        wrIdx,
	input  logic                   wrEn,
	input  logic [`DATA_WIDTH-1:0] wrData,
	output logic [`DATA_WIDTH-1:0] rdData,
	output logic [`DATA_WIDTH-1:0] rsData
);

	// register array
	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// ------------------------------
	// write port
	// ------------------------------

	// all entries cleared in reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

	// ------------------------------
	// read ports
	// ------------------------------

	// no bypass, write lands before next read
	assign rdData = regs[rdIdx];
	assign rsData = regs[rsIdx];

	// a write must name a real register
	wrIdxKnown: assert property (@(posedge clk) disable iff (!rstN)
		wrEn |-> !$isunknown(wrIdx))
		else $error("regFile: write with unknown index");

endmodule

//--- rtl/instrDecode.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module instrDecode (
	input  instrPkg::instrWord     instr,
	input  logic [`DATA_WIDTH-1:0] rsData,
	output aluOpPkg::opCode        op,
	output instrPkg::regIdx        rdIdx,
	output instrPkg::regIdx        rsIdx,
	output logic [`DATA_WIDTH-1:0] opB,
	output logic                   writesDest,
	output logic                   setsFlags
);

	// fill bit for the upper part of the immediate
	logic immFill;
	// immediate widened to data width
	logic [`DATA_WIDTH-1:0] immExt;

	// ------------------------------
	// fields
	// ------------------------------

	assign op = instr.op;
	// destination doubles as operand A
	assign rdIdx = instr.rDest;
	assign rsIdx = instr.rSrc;

	// ------------------------------
	// operand B
	// ------------------------------

	// sign bit only with signExt, zeros otherwise
	assign immFill = instr.signExt & instr.imm[`IMM_WIDTH-1];
	assign immExt = {{(`DATA_WIDTH - `IMM_WIDTH){immFill}}, instr.imm};

	assign opB = instr.immSel ? immExt : rsData;

	// ------------------------------
	// enables
	// ------------------------------

	// undefined codes neither write nor touch flags
	always_comb begin
		writesDest = 1'b0;
		setsFlags = 1'b0;
		case (instr.op)
			// arithmetic, result and flags
			aluOpPkg::ADD,
			aluOpPkg::SUB: begin
				writesDest = 1'b1;
				setsFlags = 1'b1;
			end
			// compare, flags only
			aluOpPkg::CMP:
				setsFlags = 1'b1;
			// logic, shifts and move keep old flags
			aluOpPkg::AND,
			aluOpPkg::OR,
			aluOpPkg::XOR,
			aluOpPkg::NOT,
			aluOpPkg::LSH,
			aluOpPkg::RSH,
			aluOpPkg::ARSH,
			aluOpPkg::MOV:
				writesDest = 1'b1;
			default: begin
				writesDest = 1'b0;
				setsFlags = 1'b0;
			end
		endcase
	end

endmodule

//--- rtl/execCore.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module execCore (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   instrValid,
	input  instrPkg::instrWord     instr,
	output logic [`DATA_WIDTH-1:0] result,
	output logic                   resultValid,
	output aluOpPkg::flagVec       flags
);

	// decode outputs
	aluOpPkg::opCode op;
	instrPkg::regIdx rdIdx;
	instrPkg::regIdx rsIdx;
	logic [`DATA_WIDTH-1:0] opB;
	logic writesDest;
	logic setsFlags;

	// register file reads
	logic [`DATA_WIDTH-1:0] rdData;
	logic [`DATA_WIDTH-1:0] rsData;

	// alu outputs
	logic [`DATA_WIDTH-1:0] aluResult;
	aluOpPkg::flagVec aluFlags;

	// strobed enables
	logic wrEn;
	logic flagEn;

	// ------------------------------
	// datapath
	// ------------------------------

	instrDecode uDecode (
		.instr      (instr),
		.rsData     (rsData),
		.op         (op),
		.rdIdx      (rdIdx),
		.rsIdx      (rsIdx),
		.opB        (opB),
		.writesDest (writesDest),
		.setsFlags  (setsFlags)
	);

	// write back goes to the operand A register
	regFile uRegFile (
		.clk    (clk),
		.rstN   (rstN),
		.rdIdx  (rdIdx),
		.rsIdx  (rsIdx),
		.wrIdx  (rdIdx),
		.wrEn   (wrEn),
		.wrData (aluResult),
		.rdData (rdData),
		.rsData (rsData)
	);

	alu uAlu (
		.a        (rdData),
		.b        (opB),
		.op       (op),
		.y        (aluResult),
		.flagsOut (aluFlags)
	);

	assign wrEn = instrValid & writesDest;
	assign flagEn = instrValid & setsFlags;

	// ------------------------------
	// output registers
	// ------------------------------

	// same edge as the register write, one cycle latency
	always_ff @(posedge clk) begin
		if (!rstN) begin
			result <= '0;
			resultValid <= 1'b0;
			flags <= '0;
		end else begin
			resultValid <= instrValid;
			if (instrValid) begin
				result <= aluResult;
			end
			// only ADD, SUB, CMP move the flags
			if (flagEn) begin
				flags <= aluFlags;
			end
		end
	end

	// CMP only compares, every other legal opcode writes back
	writeEnDecode: assert property (@(posedge clk) disable iff (!rstN)
		instrValid && !$isunknown(op) && (op <= aluOpPkg::MOV) |->
			(wrEn == (op != aluOpPkg::CMP)))
		else $error("execCore: write enable does not match the opcode");

endmodule

//--- verification/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
	parameter int halfPeriod = 4,
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic rstN
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// low for the first two rising edges
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

//--- verification/execCoreTb.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module execCoreTb;

	localparam int tableLen = 26;
	localparam int randomCount = 200;
	// reset and drain fit in the margin
	localparam int cycleLimit = tableLen + randomCount + 20;

	logic clk;
	logic rstN;
	logic instrValid;
	instrPkg::instrWord instr;
	logic [`DATA_WIDTH-1:0] result;
	logic resultValid;
	aluOpPkg::flagVec flags;

	// directed table, instruction and expected outputs
	instrPkg::instrWord tblInstr [tableLen];
	logic [`DATA_WIDTH-1:0] tblResult [tableLen];
	aluOpPkg::flagVec tblFlags [tableLen];
	int tblCount = 0;

	// reference model state
	logic [`DATA_WIDTH-1:0] modelRegs [`REG_COUNT];
	aluOpPkg::flagVec modelFlags;

	// expected responses in issue order
	logic [`DATA_WIDTH-1:0] expResultQ [$];
	aluOpPkg::flagVec expFlagsQ [$];
	// strobe seen at the last edge
	logic expValid = 1'b0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic [31:0] randState = 32'ha238b7f2;

	clockGen uClockGen (
		.clk  (clk),
		.rstN (rstN)
	);

	execCore DUT (
		.clk         (clk),
		.rstN        (rstN),
		.instrValid  (instrValid),
		.instr       (instr),
		.result      (result),
		.resultValid (resultValid),
		.flags       (flags)
	);

	// ------------------------------
	// helpers
	// ------------------------------

	function automatic instrPkg::instrWord makeInstr(input aluOpPkg::opCode op,
			input logic immSel, input logic signExt, input logic [3:0] rDest,
			input logic [3:0] rSrc, input logic [7:0] imm);
		instrPkg::instrWord w;
		w.op = op;
		w.immSel = immSel;
		w.signExt = signExt;
		w.rDest = rDest;
		w.rSrc = rSrc;
		w.imm = imm;
		return w;
	endfunction

	// xorshift32
	function automatic logic [31:0] nextRand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic addEntry(input aluOpPkg::opCode op, input logic immSel, input logic signExt,
			input logic [3:0] rDest, input logic [3:0] rSrc, input logic [7:0] imm,
			input logic [15:0] expR, input aluOpPkg::flagVec expF);
		tblInstr[tblCount] = makeInstr(op, immSel, signExt, rDest, rSrc, imm);
		tblResult[tblCount] = expR;
		tblFlags[tblCount] = expF;
		tblCount++;
	endtask

	// behavioral model, A is rDest, B is rSrc or the immediate
	task automatic modelExecute(input instrPkg::instrWord w, output logic [15:0] res,
			output aluOpPkg::flagVec flg);
		logic [15:0] a;
		logic [15:0] b;
		logic [16:0] full;
		logic isArith;
		int sa;
		int sb;
		int sr;
		a = modelRegs[w.rDest];
		if (!w.immSel)
			b = modelRegs[w.rSrc];
		else if (w.signExt && w.imm[7])
			b = 16'hFF00 | w.imm;
		else
			b = {8'h00, w.imm};
		sa = $signed(a);
		sb = $signed(b);
		full = '0;
		sr = 0;
		isArith = (w.op == aluOpPkg::ADD) || (w.op == aluOpPkg::SUB) || (w.op == aluOpPkg::CMP);
		if (w.op == aluOpPkg::ADD) begin
			full = a + b;
			sr = sa + sb;
		end else if (isArith) begin
			full = a + {1'b0, ~b} + 17'd1;
			sr = sa - sb;
		end
		case (w.op)
			aluOpPkg::AND: res = a & b;
			aluOpPkg::OR: res = a | b;
			aluOpPkg::XOR: res = a ^ b;
			aluOpPkg::NOT: res = ~b;
			aluOpPkg::LSH: res = b << 1;
			aluOpPkg::RSH: res = b >> 1;
			aluOpPkg::ARSH: res = $signed(b) >>> 1;
			aluOpPkg::MOV: res = b;
			default: res = full[15:0];
		endcase
		// overflow means the true signed result leaves 16 bits
		if (isArith) begin
			modelFlags[aluOpPkg::flagC] = full[16];
			modelFlags[aluOpPkg::flagL] = a < b;
			modelFlags[aluOpPkg::flagF] = (sr > 32767) || (sr < -32768);
			modelFlags[aluOpPkg::flagZ] = (full[15:0] == 16'h0000);
			modelFlags[aluOpPkg::flagN] = sa < sb;
		end
		if (w.op != aluOpPkg::CMP)
			modelRegs[w.rDest] = res;
		flg = modelFlags;
	endtask

	// ------------------------------
	// output checks
	// ------------------------------

	// DUT samples the old strobe at this edge too
	always @(posedge clk) begin
		expValid <= rstN && instrValid;
	end

	// outputs settle after the rising edge
	always @(negedge clk) begin : checkOutputs
		logic [15:0] expR;
		aluOpPkg::flagVec expF;
		if (rstN) begin
			if (resultValid !== expValid) begin
				$display("error at %0t: resultValid expected %b got %b", $time, expValid,
					resultValid);
				errors++;
			end
			if (resultValid === 1'b1 && expResultQ.size() == 0) begin
				$display("result pulse at %0t with no instruction pending", $time);
				errors++;
			end else if (resultValid === 1'b1) begin
				expR = expResultQ.pop_front();
				expF = expFlagsQ.pop_front();
				checks++;
				if (result !== expR) begin
					$display("error at %0t: result expected %h got %h", $time, expR, result);
					errors++;
				end
				if (flags !== expF) begin
					$display("error at %0t: flags expected %b got %b", $time, expF, flags);
					errors++;
				end
			end
		end
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout after %0d cycles, %0d results still pending", cycles,
				expResultQ.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------

	initial begin : runTests
		instrPkg::instrWord w;
		logic [15:0] r;
		aluOpPkg::flagVec f;
		instrValid = 1'b0;
		instr = '0;
		modelFlags = '0;
		for (int i = 0; i < `REG_COUNT; i++)
			modelRegs[i] = '0;

		// reset state, all registers read as zero
		addEntry(aluOpPkg::MOV, 1'b0, 1'b0, 4'd0, 4'd1, 8'h00, 16'h0000, 5'b00000);
		addEntry(aluOpPkg::MOV, 1'b0, 1'b0, 4'd5, 4'd15, 8'h00, 16'h0000, 5'b00000);
		// immediate extension and read back
		addEntry(aluOpPkg::MOV, 1'b1, 1'b1, 4'd1, 4'd0, 8'h80, 16'hFF80, 5'b00000);
		addEntry(aluOpPkg::MOV, 1'b1, 1'b0, 4'd2, 4'd0, 8'h80, 16'h0080, 5'b00000);
		addEntry(aluOpPkg::MOV, 1'b0, 1'b0, 4'd3, 4'd1, 8'h00, 16'hFF80, 5'b00000);
		addEntry(aluOpPkg::MOV, 1'b1, 1'b1, 4'd4, 4'd0, 8'hFF, 16'hFFFF, 5'b00000);
		addEntry(aluOpPkg::RSH, 1'b0, 1'b0, 4'd4, 4'd4, 8'h00, 16'h7FFF, 5'b00000);
		addEntry(aluOpPkg::MOV, 1'b1, 1'b0, 4'd6, 4'd0, 8'h01, 16'h0001, 5'b00000);
		// 7FFF + 1, signed overflow
		addEntry(aluOpPkg::ADD, 1'b0, 1'b0, 4'd4, 4'd6, 8'h00, 16'h8000, 5'b00100);
		addEntry(aluOpPkg::ARSH, 1'b0, 1'b0, 4'd9, 4'd4, 8'h00, 16'hC000, 5'b00100);
		// carry out
		addEntry(aluOpPkg::ADD, 1'b0, 1'b0, 4'd1, 4'd3, 8'h00, 16'hFF00, 5'b00001);
		addEntry(aluOpPkg::MOV, 1'b1, 1'b0, 4'd7, 4'd0, 8'h00, 16'h0000, 5'b00001);
		addEntry(aluOpPkg::ADD, 1'b0, 1'b0, 4'd7, 4'd7, 8'h00, 16'h0000, 5'b01000);
		// subtract, zero with carry, borrow, overflow
		addEntry(aluOpPkg::SUB, 1'b0, 1'b0, 4'd3, 4'd3, 8'h00, 16'h0000, 5'b01001);
		addEntry(aluOpPkg::SUB, 1'b0, 1'b0, 4'd6, 4'd2, 8'h00, 16'hFF81, 5'b10010);
		addEntry(aluOpPkg::SUB, 1'b0, 1'b0, 4'd4, 4'd2, 8'h00, 16'h7F80, 5'b10101);
		// compare keeps r2 at 0080
		addEntry(aluOpPkg::CMP, 1'b0, 1'b0, 4'd2, 4'd1, 8'h00, 16'h0180, 5'b00010);
		addEntry(aluOpPkg::CMP, 1'b1, 1'b0, 4'd2, 4'd0, 8'h80, 16'h0000, 5'b01001);
		addEntry(aluOpPkg::MOV, 1'b0, 1'b0, 4'd0, 4'd2, 8'h00, 16'h0080, 5'b01001);
		// logic and shifts hold the compare flags
		addEntry(aluOpPkg::AND, 1'b0, 1'b0, 4'd1, 4'd6, 8'h00, 16'hFF00, 5'b01001);
		addEntry(aluOpPkg::OR, 1'b0, 1'b0, 4'd2, 4'd6, 8'h00, 16'hFF81, 5'b01001);
		addEntry(aluOpPkg::XOR, 1'b1, 1'b0, 4'd2, 4'd0, 8'h0F, 16'hFF8E, 5'b01001);
		addEntry(aluOpPkg::NOT, 1'b0, 1'b0, 4'd5, 4'd2, 8'h00, 16'h0071, 5'b01001);
		addEntry(aluOpPkg::LSH, 1'b0, 1'b0, 4'd5, 4'd1, 8'h00, 16'hFE00, 5'b01001);
		addEntry(aluOpPkg::RSH, 1'b0, 1'b0, 4'd10, 4'd9, 8'h00, 16'h6000, 5'b01001);
		addEntry(aluOpPkg::MOV, 1'b0, 1'b0, 4'd11, 4'd5, 8'h00, 16'hFE00, 5'b01001);

		@(negedge clk);
		while (!rstN)
			@(negedge clk);
		if (resultValid !== 1'b0) begin
			$display("error at %0t: resultValid expected 0 got %b", $time, resultValid);
			errors++;
		end
		if (flags !== 5'b00000) begin
			$display("error at %0t: flags expected 00000 got %b", $time, flags);
			errors++;
		end
		if (result !== 16'h0000) begin
			$display("error at %0t: result expected 0000 got %h", $time, result);
			errors++;
		end

		// directed table, back to back
		for (int i = 0; i < tableLen; i++) begin
			@(posedge clk);
			instrValid <= 1'b1;
			instr <= tblInstr[i];
			// model only tracks state here
			modelExecute(tblInstr[i], r, f);
			expResultQ.push_back(tblResult[i]);
			expFlagsQ.push_back(tblFlags[i]);
		end

		// random phase against the model
		for (int i = 0; i < randomCount; i++) begin
			randState = nextRand(randState);
			w = makeInstr(aluOpPkg::opCode'(randState[31:27] % 11), randState[8],
				randState[9], randState[13:10], randState[17:14], randState[25:18]);
			@(posedge clk);
			instrValid <= 1'b1;
			instr <= w;
			modelExecute(w, r, f);
			expResultQ.push_back(r);
			expFlagsQ.push_back(f);
		end

		@(posedge clk);
		instrValid <= 1'b0;
		while (expResultQ.size() > 0)
			@(negedge clk);
		// one idle cycle so the checker sees the pulse drop
		repeat (2) @(posedge clk);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- execCore.f
+incdir+rtl
rtl/aluOpPkg.sv
rtl/instrPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/instrDecode.sv
rtl/execCore.sv
verification/clockGen.sv
verification/execCoreTb.sv
